//--- verilog/trace_defines.svh
`ifndef TRACE_DEFINES_SVH
`define TRACE_DEFINES_SVH

// ------------------------------
// Trace path sizing
// ------------------------------

// Cores presenting a branch trace record
`define TRACE_NUM_CORES 2

// Width of a full program counter
`define TRACE_PC_W 64

// Crossing FIFO holds 2**TRACE_LOG_DEPTH records
`define TRACE_LOG_DEPTH 2

// Flops on the incoming read pointer
`define TRACE_SYNC_STAGES 3

`endif

//--- verilog/trace_pkg.sv
`include "trace_defines.svh"

package trace_pkg;

  // ------------------------------
  // Raw fields from a core
  // ------------------------------

  typedef logic [1:0]             priv_lvl_t;
  typedef logic [`TRACE_PC_W-1:0] pc_t;
  typedef logic [3:0]             ctr_type_t;
  typedef logic [31:0]            instr_t;

  // One half of a split PC or the metadata word
  typedef logic [31:0]            word_t;

  // ------------------------------
  // Snooper record layout from the MSB down
  // ------------------------------

  typedef struct packed {
    priv_lvl_t priv;
    word_t     pc_src_h;
    word_t     pc_src_l;
    word_t     pc_dst_h;
    word_t     pc_dst_l;
    word_t     metadata;
    instr_t    opcode;
  } trace_rec_t;

endpackage

//--- verilog/cdc_pkg.sv
`include "trace_defines.svh"

package cdc_pkg;

  // Slot count and width of one stored record
  localparam int unsigned NUM_SLOTS = 2 ** `TRACE_LOG_DEPTH;
  localparam int unsigned SLOT_W    = $bits(trace_pkg::trace_rec_t);

  // Pointers carry one extra wrap bit beyond the slot index
  typedef logic [`TRACE_LOG_DEPTH:0] gray_ptr_t;
  typedef logic [`TRACE_LOG_DEPTH:0] bin_ptr_t;

  // All slots side by side with slot n starting at bit n*SLOT_W
  typedef logic [NUM_SLOTS*SLOT_W-1:0] fifo_store_t;

endpackage

//--- verilog/trace_capture.sv
`timescale 1ns/1ps

`include "trace_defines.svh"

module trace_capture (
  input  logic                                         clk_i,
  input  logic                                         arst_n_i,
  input  logic                                         core_select_i,
  input  trace_pkg::priv_lvl_t [`TRACE_NUM_CORES-1:0]  priv_i,
  input  trace_pkg::pc_t       [`TRACE_NUM_CORES-1:0]  pc_src_i,
  input  trace_pkg::pc_t       [`TRACE_NUM_CORES-1:0]  pc_dst_i,
  input  trace_pkg::ctr_type_t [`TRACE_NUM_CORES-1:0]  ctr_type_i,
  input  trace_pkg::instr_t    [`TRACE_NUM_CORES-1:0]  instr_i,
  input  logic                 [`TRACE_NUM_CORES-1:0]  pc_valid_i,
  output logic                                         cap_valid_o,
  output trace_pkg::priv_lvl_t                         cap_priv_o,
  output trace_pkg::pc_t                               cap_pc_src_o,
  output trace_pkg::pc_t                               cap_pc_dst_o,
  output trace_pkg::ctr_type_t                         cap_ctr_type_o,
  output trace_pkg::instr_t                            cap_instr_o
);

  import trace_pkg::*;

  logic      sel_valid;
  priv_lvl_t sel_priv;
  pc_t       sel_pc_src;
  pc_t       sel_pc_dst;
  ctr_type_t sel_ctr_type;
  instr_t    sel_instr;

  // Record of the selected core
  always_comb begin
    sel_valid    = pc_valid_i[core_select_i];
    sel_priv     = priv_i[core_select_i];
    sel_pc_src   = pc_src_i[core_select_i];
    sel_pc_dst   = pc_dst_i[core_select_i];
    sel_ctr_type = ctr_type_i[core_select_i];
    sel_instr    = instr_i[core_select_i];
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cap_valid_o <= 1'b0;
    end else begin
      cap_valid_o <= sel_valid;
    end
  end

  // Fields load every cycle whether valid or not
  always_ff @(posedge clk_i) begin
    cap_priv_o     <= sel_priv;
    cap_pc_src_o   <= sel_pc_src;
    cap_pc_dst_o   <= sel_pc_dst;
    cap_ctr_type_o <= sel_ctr_type;
    cap_instr_o    <= sel_instr;
  end

endmodule

//--- verilog/trace_pack.sv
`timescale 1ns/1ps

module trace_pack (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  logic                 cap_valid_i,
  input  trace_pkg::priv_lvl_t cap_priv_i,
  input  trace_pkg::pc_t       cap_pc_src_i,
  input  trace_pkg::pc_t       cap_pc_dst_i,
  input  trace_pkg::ctr_type_t cap_ctr_type_i,
  input  trace_pkg::instr_t    cap_instr_i,
  output logic                 rec_valid_o,
  output trace_pkg::trace_rec_t rec_o
);

  import trace_pkg::*;

  // Zero bits above the transfer type in the metadata word
  localparam int unsigned META_PAD = $bits(word_t) - $bits(ctr_type_t);

  trace_rec_t rec_d;

  // ------------------------------
  // Snooper layout
  // ------------------------------

  always_comb begin
    rec_d.priv     = cap_priv_i;
    // Bit 63 is dropped and the top of each high half is zero
    rec_d.pc_src_h = {1'b0, cap_pc_src_i[62:32]};
    // Alignment bit forced low
    rec_d.pc_src_l = {cap_pc_src_i[31:1], 1'b0};
    rec_d.pc_dst_h = {1'b0, cap_pc_dst_i[62:32]};
    rec_d.pc_dst_l = {cap_pc_dst_i[31:1], 1'b0};
    rec_d.metadata = {{META_PAD{1'b0}}, cap_ctr_type_i};
    rec_d.opcode   = cap_instr_i;
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rec_valid_o <= 1'b0;
    end else begin
      rec_valid_o <= cap_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    rec_o <= rec_d;
  end

endmodule

//--- verilog/trace_cdc_src.sv
`timescale 1ns/1ps

`include "trace_defines.svh"

module trace_cdc_src (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  logic                  rec_valid_i,
  input  trace_pkg::trace_rec_t rec_i,
  input  cdc_pkg::gray_ptr_t    async_rptr_i,
  output cdc_pkg::fifo_store_t  async_data_o,
  output cdc_pkg::gray_ptr_t    async_wptr_o
);

  import cdc_pkg::*;

  // Full when the top two gray bits differ and the rest match
  localparam gray_ptr_t FULL_MASK = gray_ptr_t'(2'b11) << (`TRACE_LOG_DEPTH - 1);

  bin_ptr_t                          wptr_bin_q;
  bin_ptr_t                          wptr_bin_next;
  gray_ptr_t                         wptr_gray_q;
  gray_ptr_t                         wptr_gray_next;
  gray_ptr_t [`TRACE_SYNC_STAGES-1:0] rptr_sync_q;
  gray_ptr_t                         rptr_synced;
  fifo_store_t                       store_q;
  logic                              full;
  logic                              push;

  // ------------------------------
  // Read pointer synchronizer
  // ------------------------------

  // Stage 0 samples the destination pointer and the last stage feeds the full check
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rptr_sync_q <= '0;
    end else begin
      rptr_sync_q <= {rptr_sync_q[`TRACE_SYNC_STAGES-2:0], async_rptr_i};
    end
  end

  assign rptr_synced = rptr_sync_q[`TRACE_SYNC_STAGES-1];

  // ------------------------------
  // Write side
  // ------------------------------

  assign full = (wptr_gray_q == (rptr_synced ^ FULL_MASK));

  // A record seen while full is lost since nothing upstream stalls
  assign push = rec_valid_i & ~full;

  assign wptr_bin_next  = wptr_bin_q + 1'b1;
  assign wptr_gray_next = wptr_bin_next ^ (wptr_bin_next >> 1);

  // Gray copy is registered so only one bit toggles per write
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wptr_bin_q  <= '0;
      wptr_gray_q <= '0;
    end else if (push) begin
      wptr_bin_q  <= wptr_bin_next;
      wptr_gray_q <= wptr_gray_next;
    end
  end

  // Slot picked by the low write pointer bits
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      store_q <= '0;
    end else if (push) begin
      store_q[wptr_bin_q[`TRACE_LOG_DEPTH-1:0]*SLOT_W +: SLOT_W] <= rec_i;
    end
  end

  // Raw asynchronous view for the destination domain
  assign async_data_o = store_q;
  assign async_wptr_o = wptr_gray_q;

endmodule

//--- verilog/cfi_trace_top.sv
`timescale 1ns/1ps

`include "trace_defines.svh"

module cfi_trace_top (
  input  logic                                         clk_i,
  input  logic                                         arst_n_i,
  input  logic                                         core_select_i,
  input  trace_pkg::priv_lvl_t [`TRACE_NUM_CORES-1:0]  priv_i,
  input  trace_pkg::pc_t       [`TRACE_NUM_CORES-1:0]  pc_src_i,
  input  trace_pkg::pc_t       [`TRACE_NUM_CORES-1:0]  pc_dst_i,
  input  trace_pkg::ctr_type_t [`TRACE_NUM_CORES-1:0]  ctr_type_i,
  input  trace_pkg::instr_t    [`TRACE_NUM_CORES-1:0]  instr_i,
  input  logic                 [`TRACE_NUM_CORES-1:0]  pc_valid_i,
  input  cdc_pkg::gray_ptr_t                           async_rptr_i,
  output cdc_pkg::fifo_store_t                         async_data_o,
  output cdc_pkg::gray_ptr_t                           async_wptr_o
);

  import trace_pkg::*;

  // Capture to pack
  logic      cap_valid;
  priv_lvl_t cap_priv;
  pc_t       cap_pc_src;
  pc_t       cap_pc_dst;
  ctr_type_t cap_ctr_type;
  instr_t    cap_instr;

  // Pack to crossing source
  logic       rec_valid;
  trace_rec_t rec;

  trace_capture u_capture (
    .clk_i          ( clk_i         ),
    .arst_n_i       ( arst_n_i      ),
    .core_select_i  ( core_select_i ),
    .priv_i         ( priv_i        ),
    .pc_src_i       ( pc_src_i      ),
    .pc_dst_i       ( pc_dst_i      ),
    .ctr_type_i     ( ctr_type_i    ),
    .instr_i        ( instr_i       ),
    .pc_valid_i     ( pc_valid_i    ),
    .cap_valid_o    ( cap_valid     ),
    .cap_priv_o     ( cap_priv      ),
    .cap_pc_src_o   ( cap_pc_src    ),
    .cap_pc_dst_o   ( cap_pc_dst    ),
    .cap_ctr_type_o ( cap_ctr_type  ),
    .cap_instr_o    ( cap_instr     )
  );

  trace_pack u_pack (
    .clk_i          ( clk_i        ),
    .arst_n_i       ( arst_n_i     ),
    .cap_valid_i    ( cap_valid    ),
    .cap_priv_i     ( cap_priv     ),
    .cap_pc_src_i   ( cap_pc_src   ),
    .cap_pc_dst_i   ( cap_pc_dst   ),
    .cap_ctr_type_i ( cap_ctr_type ),
    .cap_instr_i    ( cap_instr    ),
    .rec_valid_o    ( rec_valid    ),
    .rec_o          ( rec          )
  );

  trace_cdc_src u_cdc_src (
    .clk_i        ( clk_i        ),
    .arst_n_i     ( arst_n_i     ),
    .rec_valid_i  ( rec_valid    ),
    .rec_i        ( rec          ),
    .async_rptr_i ( async_rptr_i ),
    .async_data_o ( async_data_o ),
    .async_wptr_o ( async_wptr_o )
  );

endmodule

//--- dv/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk_o,
  output logic arst_n_o
);

  // 4 ns period
  initial begin
    clk_o = 1'b0;
    forever #2 clk_o = ~clk_o;
  end

  // Reset held for 4 cycles
  initial begin
    arst_n_o = 1'b0;
    repeat (4) @(posedge clk_o);
    arst_n_o <= 1'b1;
  end

endmodule

//--- dv/tb_cfi_trace.sv
`timescale 1ns/1ps

`include "trace_defines.svh"

module tb_cfi_trace;

  import trace_pkg::*;
  import cdc_pkg::*;

  localparam int REC_W     = $bits(trace_rec_t);
  localparam int MAX_CYCLE = 2000;

  logic                                 clk_i;
  logic                                 arst_n;
  logic                                 core_select_i;
  priv_lvl_t [`TRACE_NUM_CORES-1:0]     priv_i;
  pc_t       [`TRACE_NUM_CORES-1:0]     pc_src_i;
  pc_t       [`TRACE_NUM_CORES-1:0]     pc_dst_i;
  ctr_type_t [`TRACE_NUM_CORES-1:0]     ctr_type_i;
  instr_t    [`TRACE_NUM_CORES-1:0]     instr_i;
  logic      [`TRACE_NUM_CORES-1:0]     pc_valid_i;
  fifo_store_t                          async_data_o;
  gray_ptr_t                            async_wptr_o;

  // Reader model and expected records
  trace_rec_t exp_mem [0:511];
  int         exp_wr = 0;
  int         exp_rd = 0;
  bin_ptr_t   rd_bin = '0;
  gray_ptr_t  rd_gray = '0;
  gray_ptr_t  wptr_prev = '0;
  logic       stall = 1'b0;
  logic       idle_check = 1'b0;
  logic       rd_fire;
  trace_rec_t rd_slot;
  trace_rec_t rd_expect;
  bin_ptr_t   fill;

  int err_total = 0;
  int err_ptr = 0;
  int err_mark = 0;
  int wptr_steps = 0;
  int test_pass = 0;
  int test_fail = 0;
  int cycle_count = 0;

  tb_clk_gen u_clk_gen (
    .clk_o    ( clk_i  ),
    .arst_n_o ( arst_n )
  );

  cfi_trace_top dut (
    .clk_i         ( clk_i         ),
    .arst_n_i      ( arst_n        ),
    .core_select_i ( core_select_i ),
    .priv_i        ( priv_i        ),
    .pc_src_i      ( pc_src_i      ),
    .pc_dst_i      ( pc_dst_i      ),
    .ctr_type_i    ( ctr_type_i    ),
    .instr_i       ( instr_i       ),
    .pc_valid_i    ( pc_valid_i    ),
    .async_rptr_i  ( rd_gray       ),
    .async_data_o  ( async_data_o  ),
    .async_wptr_o  ( async_wptr_o  )
  );

  function automatic gray_ptr_t to_gray(bin_ptr_t b);
    return b ^ (b >> 1);
  endfunction

  function automatic bin_ptr_t to_bin(gray_ptr_t g);
    bin_ptr_t b;
    int       i;
    b[`TRACE_LOG_DEPTH] = g[`TRACE_LOG_DEPTH];
    for (i = `TRACE_LOG_DEPTH - 1; i >= 0; i--) begin
      b[i] = b[i+1] ^ g[i];
    end
    return b;
  endfunction

  // Expected record in snooper layout with split PCs and padded type
  function automatic trace_rec_t pack_expected(priv_lvl_t pv, pc_t src, pc_t dst,
                                               ctr_type_t ct, instr_t ins);
    trace_rec_t r;
    r = {pv, 1'b0, src[62:32], src[31:1], 1'b0, 1'b0, dst[62:32], dst[31:1], 1'b0,
         28'd0, ct, ins};
    return r;
  endfunction

  // ------------------------------
  // Destination side reader
  // ------------------------------

  assign rd_fire   = !stall && (rd_gray != async_wptr_o);
  assign rd_slot   = async_data_o[rd_bin[`TRACE_LOG_DEPTH-1:0]*REC_W +: REC_W];
  assign rd_expect = exp_mem[exp_rd];
  assign fill      = to_bin(async_wptr_o) - rd_bin;

  always @(posedge clk_i or negedge arst_n) begin
    if (!arst_n) begin
      rd_bin  <= '0;
      rd_gray <= '0;
      exp_rd  <= 0;
    end else if (rd_fire) begin
      rd_bin  <= rd_bin + 1'b1;
      rd_gray <= to_gray(rd_bin + 1'b1);
      exp_rd  <= exp_rd + 1;
    end
  end

  always @(posedge clk_i or negedge arst_n) begin
    if (!arst_n) begin
      wptr_prev <= '0;
    end else begin
      wptr_prev <= async_wptr_o;
      if (async_wptr_o != wptr_prev) wptr_steps <= wptr_steps + 1;
    end
  end

  // ------------------------------
  // Checks
  // ------------------------------

  a_idle: assert property (@(posedge clk_i) disable iff (!arst_n)
    idle_check |-> async_wptr_o == '0)
    else begin
      err_total++;
      $display("ERR %0t: write pointer %h moved with no valid record", $time,
               $sampled(async_wptr_o));
    end

  a_extra: assert property (@(posedge clk_i) disable iff (!arst_n)
    rd_fire |-> exp_rd < exp_wr)
    else begin
      err_total++;
      $display("Reader found a record that was never expected at %0t", $time);
    end

  a_data: assert property (@(posedge clk_i) disable iff (!arst_n)
    (rd_fire && exp_rd < exp_wr) |-> rd_slot == rd_expect)
    else begin
      err_total++;
      $display("ERR %0t: record %0d read %h, expected %h", $time, $sampled(exp_rd),
               $sampled(rd_slot), $sampled(rd_expect));
    end

  a_format: assert property (@(posedge clk_i) disable iff (!arst_n)
    rd_fire |-> (rd_slot.pc_src_l[0] == 1'b0 && rd_slot.pc_dst_l[0] == 1'b0 &&
                 rd_slot.pc_src_h[31] == 1'b0 && rd_slot.pc_dst_h[31] == 1'b0 &&
                 rd_slot.metadata[31:4] == '0))
    else begin
      err_total++;
      $display("ERR %0t: record %h has nonzero pad bits", $time, $sampled(rd_slot));
    end

  a_step: assert property (@(posedge clk_i) disable iff (!arst_n)
    async_wptr_o != wptr_prev |-> $countones(async_wptr_o ^ wptr_prev) == 1)
    else begin
      err_total++;
      err_ptr++;
      $display("ERR %0t: write pointer stepped %h to %h", $time, $sampled(wptr_prev),
               $sampled(async_wptr_o));
    end

  a_order: assert property (@(posedge clk_i) disable iff (!arst_n) fill <= 4)
    else begin
      err_total++;
      err_ptr++;
      $display("ERR %0t: read count passed write count, fill %0d", $time, $sampled(fill));
    end

  // ------------------------------
  // Stimulus
  // ------------------------------

  // Drives one cycle of records from both cores and logs the kept one
  task automatic drive_cycle(input logic sel, input logic sel_vld, input logic oth_vld,
                             input logic keep);
    priv_lvl_t  pv [2];
    pc_t        ps [2];
    pc_t        pd [2];
    ctr_type_t  ct [2];
    instr_t     ins [2];
    logic [1:0] vld;
    int         c;
    for (c = 0; c < 2; c++) begin
      pv[c]  = $urandom;
      ps[c]  = {$urandom, $urandom};
      pd[c]  = {$urandom, $urandom};
      ct[c]  = $urandom;
      ins[c] = $urandom;
    end
    vld[sel]  = sel_vld;
    vld[!sel] = oth_vld;
    @(posedge clk_i);
    core_select_i <= sel;
    for (c = 0; c < 2; c++) begin
      priv_i[c]     <= pv[c];
      pc_src_i[c]   <= ps[c];
      pc_dst_i[c]   <= pd[c];
      ctr_type_i[c] <= ct[c];
      instr_i[c]    <= ins[c];
    end
    pc_valid_i <= vld;
    if (sel_vld && keep) begin
      exp_mem[exp_wr] = pack_expected(pv[sel], ps[sel], pd[sel], ct[sel], ins[sel]);
      exp_wr++;
    end
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    repeat (4) drive_cycle(1'b0, 1'b0, 1'b0, 1'b0);
    while (exp_rd != exp_wr && n < 40) begin
      drive_cycle(1'b0, 1'b0, 1'b0, 1'b0);
      n++;
    end
    assert (exp_rd == exp_wr) else begin
      err_total++;
      $display("Reader is missing %0d records after draining", exp_wr - exp_rd);
    end
  endtask

  // Six records in a row into a stalled reader so only 4 fit
  task automatic run_burst();
    bin_ptr_t start;
    int       i;
    wait_drain();
    repeat (6) drive_cycle(1'b0, 1'b0, 1'b0, 1'b0);
    start = bin_ptr_t'(exp_wr);
    @(posedge clk_i);
    stall <= 1'b1;
    for (i = 0; i < 6; i++) drive_cycle(i[0], 1'b1, 1'b1, i < 4);
    repeat (8) drive_cycle(1'b0, 1'b0, 1'b0, 1'b0);
    assert (async_wptr_o == to_gray(start + 3'd4)) else begin
      err_total++;
      $display("ERR %0t: write pointer %h after burst, expected %h", $time,
               async_wptr_o, to_gray(start + 3'd4));
    end
    @(posedge clk_i);
    stall <= 1'b0;
    wait_drain();
  endtask

  task automatic end_test(input int num, input string name, input logic ok);
    if (ok && err_total == err_mark) begin
      test_pass++;
      $display("test %0d %s: ok", num, name);
    end else begin
      test_fail++;
      $display("test %0d %s: failed with %0d errors", num, name, err_total - err_mark);
    end
    err_mark = err_total;
  endtask

  always @(posedge clk_i) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= MAX_CYCLE) begin
      $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLE);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  initial begin
    int i;
    void'($urandom(67082));
    core_select_i = 1'b0;
    priv_i        = '0;
    pc_src_i      = '0;
    pc_dst_i      = '0;
    ctr_type_i    = '0;
    instr_i       = '0;
    pc_valid_i    = '0;
    @(posedge arst_n);

    idle_check <= 1'b1;
    for (i = 0; i < 20; i++) drive_cycle($urandom, 1'b0, 1'b0, 1'b0);
    @(posedge clk_i);
    idle_check <= 1'b0;
    end_test(1, "idle after reset", 1'b1);

    for (i = 0; i < 48; i++) begin
      drive_cycle(i >= 24, 1'b1, 1'b1, 1'b1);
      drive_cycle(i >= 24, 1'b0, 1'b0, 1'b0);
    end
    wait_drain();
    end_test(2, "core select and packing", 1'b1);

    // Spacing keeps the FIFO from filling while the reader drains
    for (i = 0; i < 60; i++) begin
      drive_cycle($urandom, $urandom, $urandom, 1'b1);
      drive_cycle($urandom, 1'b0, 1'b0, 1'b0);
    end
    wait_drain();
    end_test(3, "valid filter and order", 1'b1);

    run_burst();
    run_burst();
    end_test(4, "full drop", 1'b1);

    end_test(5, "pointer steps", err_ptr == 0 && wptr_steps > 0);

    $display("tests passed %0d, failed %0d", test_pass, test_fail);
    if (test_fail == 0 && err_total == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- tb.f
+incdir+verilog
verilog/trace_pkg.sv
verilog/cdc_pkg.sv
verilog/trace_capture.sv
verilog/trace_pack.sv
verilog/trace_cdc_src.sv
verilog/cfi_trace_top.sv
dv/tb_clk_gen.sv
dv/tb_cfi_trace.sv
